// File: mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Bus widths
`define ADDR_WIDTH       8
`define DATA_WIDTH       32
`define BURSTLEN_WIDTH   2

// RAM geometry, depth matches the full address space
`define MEM_WORDS        256

// Edges from read acceptance to the edge that launches the first beat
`define RAM_READ_LATENCY 2

// Nonzero start value for the arbiter LFSR
`define LFSR_SEED        15'd110

`endif

// File: mem_pkg.sv
`include "mem_consts.svh"

package mem_pkg;

  typedef logic [`ADDR_WIDTH-1:0]     addr_t;
  typedef logic [`DATA_WIDTH-1:0]     data_t;
  typedef logic [`BURSTLEN_WIDTH-1:0] burst_len_t;  // Zero is illegal on reads

  typedef enum logic {
    IDLE,
    BURST_READ
  } arb_state_t;

  typedef enum logic [1:0] {
    RAM_IDLE,
    RAM_WAIT,
    RAM_STREAM
  } ram_state_t;

endpackage

// File: mem_arb.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_arb (
  input  logic                clock,
  input  logic                reset_n,

  input  mem_pkg::addr_t      c1_addr,
  input  mem_pkg::burst_len_t c1_burst_len,
  input  mem_pkg::data_t      c1_data_in,
  input  logic                c1_wr,
  input  logic                c1_rd,
  output mem_pkg::data_t      c1_data_out,
  output logic                c1_waitrequest,
  output logic                c1_rd_valid,

  input  mem_pkg::addr_t      c2_addr,
  input  mem_pkg::burst_len_t c2_burst_len,
  input  mem_pkg::data_t      c2_data_in,
  input  logic                c2_wr,
  input  logic                c2_rd,
  output mem_pkg::data_t      c2_data_out,
  output logic                c2_waitrequest,
  output logic                c2_rd_valid,

  output mem_pkg::addr_t      mm_addr,
  output mem_pkg::burst_len_t mm_burst_len,
  output mem_pkg::data_t      mm_data_out,
  output logic                mm_wr,
  output logic                mm_rd,
  input  mem_pkg::data_t      mm_data_in,
  input  logic                mm_waitrequest,
  input  logic                mm_rd_valid
);

  localparam int LFSR_W = 15;

  logic                sel;            // 0 grants client 1, 1 grants client 2
  logic                next_sel;
  logic [LFSR_W-1:0]   lfsr;
  logic                rand_bit;

  mem_pkg::arb_state_t state;
  mem_pkg::arb_state_t next_state;
  mem_pkg::burst_len_t rd_count;      // Beats still to come back

  mem_pkg::burst_len_t burst_len_int;
  logic                rd_int;
  logic                wr_int;
  logic                rd_accept;
  logic                busy;

  // Read data goes to both clients, only the strobe is steered
  assign c1_data_out = mm_data_in;
  assign c2_data_out = mm_data_in;

  assign mm_addr       = sel ? c2_addr      : c1_addr;
  assign burst_len_int = sel ? c2_burst_len : c1_burst_len;
  assign mm_data_out   = sel ? c2_data_in   : c1_data_in;
  assign wr_int        = sel ? c2_wr        : c1_wr;
  assign rd_int        = sel ? c2_rd        : c1_rd;

  assign mm_burst_len = burst_len_int;

  // No new command reaches the RAM until the burst has drained
  assign mm_rd = rd_int && (state == mem_pkg::IDLE);
  assign mm_wr = wr_int && (state == mem_pkg::IDLE);

  // Also stalls the owner in the cycle after its last beat
  assign busy = mm_waitrequest || (state == mem_pkg::BURST_READ);

  assign c1_waitrequest = sel || busy;
  assign c2_waitrequest = !sel || busy;

  assign c1_rd_valid = mm_rd_valid && !sel;
  assign c2_rd_valid = mm_rd_valid && sel;

  assign rd_accept = mm_rd && !mm_waitrequest && (burst_len_int != '0);

  // Fibonacci LFSR, x^15 + x^14 + 1
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      lfsr <= `LFSR_SEED;
    end else begin
      lfsr <= {lfsr[0] ^ lfsr[1], lfsr[LFSR_W-1:1]};
    end
  end

  assign rand_bit = lfsr[0];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      rd_count <= '0;
    end else if (rd_accept) begin
      rd_count <= burst_len_int;
    end else if (state == mem_pkg::BURST_READ && mm_rd_valid && rd_count != '0) begin
      rd_count <= rd_count - 1'b1;
    end
  end

  always_comb begin
    next_state = state;
    unique case (state)
      mem_pkg::IDLE: begin
        if (rd_accept) begin
          next_state = mem_pkg::BURST_READ;
        end
      end
      mem_pkg::BURST_READ: begin
        if (rd_count == '0) begin
          next_state = mem_pkg::IDLE;
        end
      end
      default: next_state = mem_pkg::IDLE;
    endcase
  end

  // Grant may only move on an edge that lands in IDLE
  always_comb begin
    next_sel = sel;
    if (next_state == mem_pkg::IDLE) begin
      next_sel = rand_bit;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= mem_pkg::IDLE;
      sel   <= 1'b0;
    end else begin
      state <= next_state;
      sel   <= next_sel;
    end
  end

  // Owner gets no more beats than its burst asked for
  a_beat_within_burst: assert property (
    @(posedge clock) disable iff (!reset_n)
    (state == mem_pkg::BURST_READ && mm_rd_valid) |-> rd_count != '0
  );

  // Client protocol, reads must ask for at least one word
  a_rd_len_nonzero: assert property (
    @(posedge clock) disable iff (!reset_n)
    (state == mem_pkg::IDLE && rd_int) |-> burst_len_int != '0
  );

  // RAM must not return beats the arbiter is not waiting for
  a_no_beat_in_idle: assert property (
    @(posedge clock) disable iff (!reset_n)
    mm_rd_valid |-> state == mem_pkg::BURST_READ
  );

endmodule

// File: burst_ram.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module burst_ram (
  input  logic                clock,
  input  logic                reset_n,

  input  mem_pkg::addr_t      addr,
  input  mem_pkg::burst_len_t burst_len,
  input  mem_pkg::data_t      data_in,
  input  logic                wr,
  input  logic                rd,
  output mem_pkg::data_t      data_out,
  output logic                waitrequest,
  output logic                rd_valid
);

  localparam int LAT_W = $clog2(`RAM_READ_LATENCY + 1);

  mem_pkg::data_t      mem [`MEM_WORDS];

  mem_pkg::ram_state_t state;
  mem_pkg::ram_state_t next_state;
  logic [LAT_W-1:0]    wait_cnt;
  mem_pkg::burst_len_t beats_left;    // Includes the beat on the bus
  mem_pkg::addr_t      rd_addr;

  logic                rd_accept;
  logic                wr_accept;
  logic                load_beat;

  // Busy from the edge after acceptance through the last beat
  assign waitrequest = (state != mem_pkg::RAM_IDLE);
  assign rd_valid    = (state == mem_pkg::RAM_STREAM);

  assign rd_accept = rd && !waitrequest;
  assign wr_accept = wr && !waitrequest;

  // Edge that puts the next word on data_out
  assign load_beat = (state == mem_pkg::RAM_WAIT && wait_cnt == '0) ||
                     (state == mem_pkg::RAM_STREAM && beats_left > 2'd1);

  always_comb begin
    next_state = state;
    unique case (state)
      mem_pkg::RAM_IDLE: begin
        if (rd_accept) begin
          next_state = mem_pkg::RAM_WAIT;
        end
      end
      mem_pkg::RAM_WAIT: begin
        if (wait_cnt == '0) begin
          next_state = mem_pkg::RAM_STREAM;
        end
      end
      mem_pkg::RAM_STREAM: begin
        if (beats_left <= 2'd1) begin
          next_state = mem_pkg::RAM_IDLE;
        end
      end
      default: next_state = mem_pkg::RAM_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state      <= mem_pkg::RAM_IDLE;
      wait_cnt   <= '0;
      beats_left <= '0;
    end else begin
      state <= next_state;
      if (rd_accept) begin
        wait_cnt   <= LAT_W'(`RAM_READ_LATENCY - 1);
        beats_left <= burst_len;
      end else begin
        if (state == mem_pkg::RAM_WAIT && wait_cnt != '0) begin
          wait_cnt <= wait_cnt - 1'b1;
        end
        if (state == mem_pkg::RAM_STREAM) begin
          beats_left <= beats_left - 1'b1;
        end
      end
    end
  end

  // Storage and read pipeline
  always_ff @(posedge clock) begin
    if (wr_accept) begin
      mem[addr] <= data_in;
    end
    if (rd_accept) begin
      rd_addr <= addr;
    end else if (load_beat) begin
      rd_addr <= rd_addr + 1'b1;     // Wraps at MEM_WORDS
    end
    if (load_beat) begin
      data_out <= mem[rd_addr];
    end
  end

  a_rd_wr_exclusive: assert property (
    @(posedge clock) disable iff (!reset_n)
    !(rd && wr)
  );

  // First beat lands a fixed number of cycles after acceptance
  a_first_beat_latency: assert property (
    @(posedge clock) disable iff (!reset_n)
    rd_accept |=> !rd_valid [*`RAM_READ_LATENCY] ##1 rd_valid
  );

endmodule

// File: mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                clock,
  input  logic                reset_n,

  input  mem_pkg::addr_t      c1_addr,
  input  mem_pkg::burst_len_t c1_burst_len,
  input  mem_pkg::data_t      c1_data_in,
  input  logic                c1_wr,
  input  logic                c1_rd,
  output mem_pkg::data_t      c1_data_out,
  output logic                c1_waitrequest,
  output logic                c1_rd_valid,

  input  mem_pkg::addr_t      c2_addr,
  input  mem_pkg::burst_len_t c2_burst_len,
  input  mem_pkg::data_t      c2_data_in,
  input  logic                c2_wr,
  input  logic                c2_rd,
  output mem_pkg::data_t      c2_data_out,
  output logic                c2_waitrequest,
  output logic                c2_rd_valid
);

  mem_pkg::addr_t      mm_addr;
  mem_pkg::burst_len_t mm_burst_len;
  mem_pkg::data_t      mm_data_out;      // Write data toward the RAM
  mem_pkg::data_t      mm_data_in;       // Read data from the RAM
  logic                mm_wr;
  logic                mm_rd;
  logic                mm_waitrequest;
  logic                mm_rd_valid;

  mem_arb u_arb (
    .clock          (clock),
    .reset_n        (reset_n),
    .c1_addr        (c1_addr),
    .c1_burst_len   (c1_burst_len),
    .c1_data_in     (c1_data_in),
    .c1_wr          (c1_wr),
    .c1_rd          (c1_rd),
    .c1_data_out    (c1_data_out),
    .c1_waitrequest (c1_waitrequest),
    .c1_rd_valid    (c1_rd_valid),
    .c2_addr        (c2_addr),
    .c2_burst_len   (c2_burst_len),
    .c2_data_in     (c2_data_in),
    .c2_wr          (c2_wr),
    .c2_rd          (c2_rd),
    .c2_data_out    (c2_data_out),
    .c2_waitrequest (c2_waitrequest),
    .c2_rd_valid    (c2_rd_valid),
    .mm_addr        (mm_addr),
    .mm_burst_len   (mm_burst_len),
    .mm_data_out    (mm_data_out),
    .mm_wr          (mm_wr),
    .mm_rd          (mm_rd),
    .mm_data_in     (mm_data_in),
    .mm_waitrequest (mm_waitrequest),
    .mm_rd_valid    (mm_rd_valid)
  );

  burst_ram u_ram (
    .clock       (clock),
    .reset_n     (reset_n),
    .addr        (mm_addr),
    .burst_len   (mm_burst_len),
    .data_in     (mm_data_out),
    .wr          (mm_wr),
    .rd          (mm_rd),
    .data_out    (mm_data_in),
    .waitrequest (mm_waitrequest),
    .rd_valid    (mm_rd_valid)
  );

endmodule

// File: tb_mem_subsys.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_mem_subsys;

  localparam int          TIMEOUT_CYCLES = 2000;
  localparam int          RANDOM_OPS     = 300;
  localparam logic [31:0] RNG_SEED       = 32'h94209861;

  logic                clock;
  logic                reset_n;

  mem_pkg::addr_t      c1_addr;
  mem_pkg::burst_len_t c1_burst_len;
  mem_pkg::data_t      c1_data_in;
  logic                c1_wr;
  logic                c1_rd;
  mem_pkg::data_t      c1_data_out;
  logic                c1_waitrequest;
  logic                c1_rd_valid;

  mem_pkg::addr_t      c2_addr;
  mem_pkg::burst_len_t c2_burst_len;
  mem_pkg::data_t      c2_data_in;
  logic                c2_wr;
  logic                c2_rd;
  mem_pkg::data_t      c2_data_out;
  logic                c2_waitrequest;
  logic                c2_rd_valid;

  logic [31:0]         rng_state = RNG_SEED;
  mem_pkg::data_t      shadow [`MEM_WORDS];   // Mirror of the RAM contents
  mem_pkg::data_t      exp_q1 [$];
  mem_pkg::data_t      exp_q2 [$];
  int                  pend [1:2];             // Beats still owed per client
  int                  grants [1:2];           // Wins while the other client waits

  mem_subsys_top DUT (
    .clock          (clock),
    .reset_n        (reset_n),
    .c1_addr        (c1_addr),
    .c1_burst_len   (c1_burst_len),
    .c1_data_in     (c1_data_in),
    .c1_wr          (c1_wr),
    .c1_rd          (c1_rd),
    .c1_data_out    (c1_data_out),
    .c1_waitrequest (c1_waitrequest),
    .c1_rd_valid    (c1_rd_valid),
    .c2_addr        (c2_addr),
    .c2_burst_len   (c2_burst_len),
    .c2_data_in     (c2_data_in),
    .c2_wr          (c2_wr),
    .c2_rd          (c2_rd),
    .c2_data_out    (c2_data_out),
    .c2_waitrequest (c2_waitrequest),
    .c2_rd_valid    (c2_rd_valid)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Preload pattern, every address bit shows up in the word
  function automatic mem_pkg::data_t fill_word(input mem_pkg::addr_t a);
    return {a, ~a, a ^ 8'h96, a + 8'h3c};
  endfunction

  function automatic mem_pkg::data_t expected_word(input mem_pkg::addr_t a);
    return shadow[a];
  endfunction

  function automatic logic waitrequest_of(input int client);
    return (client == 1) ? c1_waitrequest : c2_waitrequest;
  endfunction

  function automatic logic rd_valid_of(input int client);
    return (client == 1) ? c1_rd_valid : c2_rd_valid;
  endfunction

  function automatic logic other_requesting(input int client);
    return (client == 1) ? (c2_rd || c2_wr) : (c1_rd || c1_wr);
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input mem_pkg::data_t got,
                            input mem_pkg::data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic drive_cmd(input int client, input logic rd, input logic wr,
                           input mem_pkg::addr_t a, input mem_pkg::burst_len_t len,
                           input mem_pkg::data_t d);
    if (client == 1) begin
      c1_rd        <= rd;
      c1_wr        <= wr;
      c1_addr      <= a;
      c1_burst_len <= len;
      c1_data_in   <= d;
    end else begin
      c2_rd        <= rd;
      c2_wr        <= wr;
      c2_addr      <= a;
      c2_burst_len <= len;
      c2_data_in   <= d;
    end
  endtask

  // Called in the cycle before the accepting edge
  function automatic void record_accept(input int client, input logic is_rd,
                                        input mem_pkg::addr_t a,
                                        input mem_pkg::burst_len_t len,
                                        input mem_pkg::data_t d);
    mem_pkg::data_t w;
    if (other_requesting(client) === 1'b1) begin
      grants[client]++;
    end
    if (!is_rd) begin
      shadow[a] = d;                  // RAM writes on the same edge
    end else begin
      for (int i = 0; i < int'(len); i++) begin
        w = expected_word(mem_pkg::addr_t'(a + i));   // Wraps like the RAM
        if (client == 1) begin
          exp_q1.push_back(w);
        end else begin
          exp_q2.push_back(w);
        end
      end
      pend[client] += int'(len);
    end
  endfunction

  task automatic issue_op(input int client, input logic is_rd, input mem_pkg::addr_t a,
                          input mem_pkg::burst_len_t len, input mem_pkg::data_t d);
    int waited;
    waited = 0;
    @(posedge clock);
    drive_cmd(client, is_rd, !is_rd, a, len, d);
    @(negedge clock);
    while (waitrequest_of(client) !== 1'b0) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        report_failure($sformatf("client %0d %s never accepted", client,
                                 is_rd ? "read" : "write"));
      end
      @(negedge clock);
    end
    record_accept(client, is_rd, a, len, d);
    @(posedge clock);                 // Accepting edge
    drive_cmd(client, 1'b0, 1'b0, a, len, d);
  endtask

  // Counts negedges from the accepting edge, beats must be back to back
  task automatic check_read_timing(input int client, input mem_pkg::burst_len_t len);
    string name;
    logic  exp;
    name = (client == 1) ? "c1_rd_valid" : "c2_rd_valid";
    for (int n = 1; n <= `RAM_READ_LATENCY + int'(len) + 1; n++) begin
      @(negedge clock);
      exp = (n > `RAM_READ_LATENCY) && (n <= `RAM_READ_LATENCY + int'(len));
      check_bit(name, rd_valid_of(client), exp);
    end
    if (pend[client] != 0) begin
      report_failure($sformatf("client %0d read beats missing after burst", client));
    end
  endtask

  task automatic directed_read(input int client, input mem_pkg::addr_t a,
                               input mem_pkg::burst_len_t len);
    issue_op(client, 1'b1, a, len, '0);
    check_read_timing(client, len);
  endtask

  task automatic run_random_client(input int client, input int n_ops);
    logic [31:0] r;
    for (int i = 0; i < n_ops; i++) begin
      r = next_rand();
      issue_op(client, r[0], r[15:8], mem_pkg::burst_len_t'(1 + int'(r[17:16]) % 3),
               next_rand());
      repeat (int'(r[19:18])) @(posedge clock);
    end
  endtask

  // Compares every returned beat and watches isolation between clients
  initial begin : read_checker
    mem_pkg::data_t exp;
    forever begin
      @(negedge clock);
      if (reset_n === 1'b1) begin
        if (pend[1] > 0) begin
          check_bit("c2_rd_valid", c2_rd_valid, 1'b0);
          check_bit("c2_waitrequest", c2_waitrequest, 1'b1);
        end
        if (pend[2] > 0) begin
          check_bit("c1_rd_valid", c1_rd_valid, 1'b0);
          check_bit("c1_waitrequest", c1_waitrequest, 1'b1);
        end
        if (c1_rd_valid === 1'b1) begin
          if (exp_q1.size() == 0) begin
            report_failure("client 1 saw rd_valid with no read outstanding");
          end else begin
            exp = exp_q1.pop_front();
            check_data("c1_data_out", c1_data_out, exp);
            pend[1]--;
          end
        end
        if (c2_rd_valid === 1'b1) begin
          if (exp_q2.size() == 0) begin
            report_failure("client 2 saw rd_valid with no read outstanding");
          end else begin
            exp = exp_q2.pop_front();
            check_data("c2_data_out", c2_data_out, exp);
            pend[2]--;
          end
        end
      end
    end
  end

  initial begin
    mem_pkg::addr_t a;
    mem_pkg::data_t d;
    int             waited;
    reset_n <= 1'b0;
    drive_cmd(1, 1'b0, 1'b0, '0, 2'd1, '0);
    drive_cmd(2, 1'b0, 1'b0, '0, 2'd1, '0);
    repeat (2) @(posedge clock);
    reset_n <= 1'b1;

    // Reset values, sel starts on client 1
    @(negedge clock);
    check_bit("c1_waitrequest", c1_waitrequest, 1'b0);
    check_bit("c2_waitrequest", c2_waitrequest, 1'b1);
    check_bit("c1_rd_valid", c1_rd_valid, 1'b0);
    check_bit("c2_rd_valid", c2_rd_valid, 1'b0);

    for (int i = 0; i < `MEM_WORDS; i++) begin
      a = mem_pkg::addr_t'(i);
      issue_op((i % 2) + 1, 1'b0, a, 2'd1, fill_word(a));
    end

    // Single write then single read
    for (int c = 1; c <= 2; c++) begin
      a = mem_pkg::addr_t'(next_rand());
      d = next_rand();
      issue_op(c, 1'b0, a, 2'd1, d);
      directed_read(c, a, 2'd1);
    end

    // Bursts, the last ones cross the top of the address space
    for (int c = 1; c <= 2; c++) begin
      directed_read(c, mem_pkg::addr_t'(next_rand()), 2'd2);
      directed_read(c, mem_pkg::addr_t'(next_rand()), 2'd3);
    end
    directed_read(1, 8'hff, 2'd2);
    directed_read(2, 8'hfe, 2'd3);

    grants[1] = 0;
    grants[2] = 0;
    fork
      run_random_client(1, RANDOM_OPS / 2);
      run_random_client(2, RANDOM_OPS / 2);
    join

    waited = 0;
    while (exp_q1.size() != 0 || exp_q2.size() != 0) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        report_failure("read data never returned after random traffic");
      end
      @(negedge clock);
    end

    if (grants[1] == 0 || grants[2] == 0) begin
      report_failure("a client never won the grant while the other was waiting");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

// File: sim.f
+incdir+.
mem_pkg.sv
mem_arb.sv
burst_ram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The simulator exits nonzero on any $fatal, which fails this script.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_subsys -f sim.f -o tb_mem_subsys

./obj_dir/tb_mem_subsys
